// File: hw/fbdev_pkg.sv
//////////////////////////////////////////////////
// Framebuffer device shared definitions
//////////////////////////////////////////////////
`default_nettype none

package fbdev_pkg;

	// 640x480 at 60 Hz with one pixel per clock.
	localparam logic [11:0] H_REZ        = 12'd640;
	localparam logic [11:0] V_REZ        = 12'd480;
	localparam logic [11:0] H_SYNC_START = 12'd656;
	localparam logic [11:0] H_SYNC_END   = 12'd752;
	localparam logic [11:0] H_MAX        = 12'd800;
	localparam logic [11:0] V_SYNC_START = 12'd490;
	localparam logic [11:0] V_SYNC_END   = 12'd492;
	localparam logic [11:0] V_MAX        = 12'd525;

	localparam logic [31:0] REFRESH = 32'd60;
	localparam logic [31:0] BUFCNT  = 32'd1;

	localparam int PXCNT = int'(H_REZ) * int'(V_REZ);
	localparam int PX_CW = $clog2(PXCNT);

	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_SLACK = 4;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
	localparam int FIFO_CW    = FIFO_AW + 1;
	localparam int IF_W       = $clog2(FIFO_SLACK + 1);

	localparam logic [31:0] M_ADDR_OFFSET = 32'h1000;

	localparam logic [1:0] PINOOP = 2'b00;
	localparam logic [1:0] PIWROP = 2'b01;
	localparam logic [1:0] PIRDOP = 2'b10;
	localparam logic [1:0] PIRWOP = 2'b11;

	localparam logic [1:0] CMDSRCSET  = 2'd0;
	localparam logic [1:0] CMDGETINFO = 2'd1;

	localparam logic [29:0] GETINFO_WIDTH  = 30'd0;
	localparam logic [29:0] GETINFO_HEIGHT = 30'd1;
	localparam logic [29:0] GETINFO_HZ     = 30'd2;
	localparam logic [29:0] GETINFO_BUFCNT = 30'd3;

	// Word is shown rpt+1 times.
	typedef struct packed {
		logic [7:0] rpt;
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} px_word_t;

	typedef struct packed {
		logic [1:0]  op;
		logic [29:0] addr;
	} bus_req_t;

	typedef struct packed {
		logic [11:0] h_pos;
		logic [11:0] v_pos;
		logic        hblank;
		logic        vblank;
		logic        frame_end;
	} scan_pos_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic       blank;
		logic       hsync;
		logic       vsync;
	} vga_out_t;

endpackage

`default_nettype wire

// File: hw/fb_regs.sv
//////////////////////////////////////////////////
// Command port and source address
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module fb_regs import fbdev_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [1:0]  s_op_i,
	input  logic [31:0] s_data_i,
	output logic [31:0] s_data_o,
	output logic [29:0] src_addr_o,
	output logic        vga_rst_o
);

	logic        src_valid;
	logic        cmd_stb;
	logic [29:0] arg;

	assign cmd_stb = (s_op_i == PIRWOP);
	assign arg = s_data_i[31:2];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			src_valid <= 1'b0;
		end else if (cmd_stb && s_data_i[1:0] == CMDSRCSET) begin
			// All ones detaches the frame.
			src_valid <= ~&arg;
		end
	end

	always_ff @(posedge clk_i) begin
		if (cmd_stb) begin
			case (s_data_i[1:0])
				CMDSRCSET: begin
					if (!(&arg))
						src_addr_o <= arg - M_ADDR_OFFSET[31:2];
					// Size of the command window in bytes.
					s_data_o <= 32'd4;
				end
				CMDGETINFO: begin
					case (arg)
						GETINFO_WIDTH:  s_data_o <= 32'(H_REZ);
						GETINFO_HEIGHT: s_data_o <= 32'(V_REZ);
						GETINFO_HZ:     s_data_o <= REFRESH;
						GETINFO_BUFCNT: s_data_o <= BUFCNT;
						default:        s_data_o <= 32'd0;
					endcase
				end
				default: begin
				end
			endcase
		end
	end

	// Display held in reset until a frame is attached.
	assign vga_rst_o = rst_i || !src_valid;

endmodule

`default_nettype wire

// File: hw/scan_timer.sv
//////////////////////////////////////////////////
// Scan position and sync timing
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scan_timer import fbdev_pkg::*; (
	input  logic      clk_i,
	input  logic      vga_rst_o,
	output scan_pos_t pos_o,
	output vga_out_t  sync_o
);

	logic [11:0] h_pos;
	logic [11:0] v_pos;
	logic        h_last;
	logic        v_last;
	vga_out_t    sync_next;

	assign h_last = (h_pos == H_MAX - 12'd1);
	assign v_last = (v_pos == V_MAX - 12'd1);

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			h_pos <= 12'd0;
			v_pos <= 12'd0;
		end else if (h_last) begin
			h_pos <= 12'd0;
			if (v_last)
				v_pos <= 12'd0;
			else
				v_pos <= v_pos + 12'd1;
		end else begin
			h_pos <= h_pos + 12'd1;
		end
	end

	assign pos_o.h_pos     = h_pos;
	assign pos_o.v_pos     = v_pos;
	assign pos_o.hblank    = (h_pos >= H_REZ);
	assign pos_o.vblank    = (v_pos >= V_REZ);
	assign pos_o.frame_end = h_last && v_last;

	always_comb begin
		sync_next       = '0;
		sync_next.blank = pos_o.hblank || pos_o.vblank;
		sync_next.hsync = (h_pos >= H_SYNC_START) && (h_pos < H_SYNC_END);
		sync_next.vsync = (v_pos >= V_SYNC_START) && (v_pos < V_SYNC_END);
	end

	// Sync lags the position by one clock.
	always_ff @(posedge clk_i) begin
		if (vga_rst_o)
			sync_o <= '0;
		else
			sync_o <= sync_next;
	end

endmodule

`default_nettype wire

// File: hw/fetch_fsm.sv
//////////////////////////////////////////////////
// Pixel fetch engine
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module fetch_fsm import fbdev_pkg::*; (
	input  logic               clk_i,
	input  logic               vga_rst_o,
	input  scan_pos_t          pos_i,
	input  logic [29:0]        src_addr_i,
	output bus_req_t           m_req_o,
	input  logic               m_rdy_i,
	input  logic [FIFO_CW-1:0] fifo_count_i,
	output logic               fifo_write_o,
	output logic               fifo_clear_o
);

	typedef enum logic [1:0] {
		IDLE,
		FLUSH,
		FETCH,
		DONE
	} state_t;

	state_t             state;
	logic [29:0]        addr;
	logic [PX_CW-1:0]   word_cnt;
	logic [IF_W-1:0]    in_flight;
	logic [IF_W-1:0]    stale;
	logic [FIFO_CW:0]   fill;
	logic               room;
	logic               vblank_start;
	logic               accept;
	logic               ret;

	assign vblank_start = (pos_i.v_pos == V_REZ) && (pos_i.h_pos == 12'd0);

	// FIFO entries plus words already on their way.
	assign fill = (FIFO_CW+1)'(fifo_count_i) + (FIFO_CW+1)'(in_flight);
	assign room = (fill < (FIFO_CW+1)'(FIFO_DEPTH));

	assign m_req_o.op   = (state == FETCH && room) ? PIRDOP : PINOOP;
	assign m_req_o.addr = addr;

	assign accept = (m_req_o.op == PIRDOP) && m_rdy_i;
	assign ret    = (in_flight != '0) && m_rdy_i;

	// Data of reads issued before the flush is dropped.
	assign fifo_write_o = ret && (stale == '0) && (state != FLUSH);
	assign fifo_clear_o = (state == FLUSH);

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			state     <= IDLE;
			word_cnt  <= '0;
			in_flight <= '0;
			stale     <= '0;
		end else begin
			in_flight <= in_flight + IF_W'(accept) - IF_W'(ret);

			if (state == FLUSH)
				stale <= in_flight - IF_W'(ret);
			else if (ret && stale != '0)
				stale <= stale - 1'b1;

			if (vblank_start) begin
				state <= FLUSH;
			end else begin
				case (state)
					FLUSH: begin
						word_cnt <= '0;
						state    <= FETCH;
					end
					FETCH: begin
						if (accept) begin
							word_cnt <= word_cnt + 1'b1;
							if (word_cnt == PX_CW'(PXCNT - 1))
								state <= DONE;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == FLUSH)
			addr <= src_addr_i;
		else if (accept)
			addr <= addr + 30'd1;
	end

endmodule

`default_nettype wire

// File: hw/px_fifo.sv
//////////////////////////////////////////////////
// Pixel word FIFO
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module px_fifo import fbdev_pkg::*; (
	input  logic               clk_i,
	input  logic               vga_rst_o,
	input  logic               clear_i,
	input  logic               write_i,
	input  px_word_t           data_i,
	input  logic               read_i,
	output px_word_t           head_o,
	output logic               empty_o,
	output logic [FIFO_CW-1:0] count_o
);

	px_word_t           mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic               full;
	logic               do_write;
	logic               do_read;

	assign empty_o  = (count_o == '0);
	assign full     = (count_o == FIFO_CW'(FIFO_DEPTH));
	assign do_write = write_i && !full;
	assign do_read  = read_i && !empty_o;

	// The oldest word is always visible at the head.
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (do_write)
			mem[wr_ptr] <= data_i;
	end

	always_ff @(posedge clk_i) begin
		if (vga_rst_o || clear_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			count_o <= count_o + FIFO_CW'(do_write) - FIFO_CW'(do_read);
		end
	end

endmodule

`default_nettype wire

// File: hw/px_unpack.sv
//////////////////////////////////////////////////
// Pixel unpacker
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module px_unpack import fbdev_pkg::*; (
	input  logic      clk_i,
	input  logic      vga_rst_o,
	input  scan_pos_t pos_i,
	input  vga_out_t  sync_i,
	input  px_word_t  head_i,
	input  logic      empty_i,
	output logic      read_o,
	output vga_out_t  vga_o
);

	logic [7:0] px_cnt;
	logic [7:0] red_r;
	logic [7:0] green_r;
	logic [7:0] blue_r;
	logic       active;
	logic       show;
	logic       last_px;

	assign active  = !pos_i.hblank && !pos_i.vblank;
	// Underrun stalls the word and shows black.
	assign show    = active && !empty_i;
	assign last_px = (px_cnt == head_i.rpt);
	assign read_o  = show && last_px;

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			px_cnt  <= 8'd0;
			red_r   <= 8'd0;
			green_r <= 8'd0;
			blue_r  <= 8'd0;
		end else begin
			if (pos_i.frame_end)
				px_cnt <= 8'd0;
			else if (show)
				px_cnt <= last_px ? 8'd0 : px_cnt + 8'd1;

			if (show) begin
				red_r   <= head_i.red;
				green_r <= head_i.green;
				blue_r  <= head_i.blue;
			end else begin
				red_r   <= 8'd0;
				green_r <= 8'd0;
				blue_r  <= 8'd0;
			end
		end
	end

	// Colour registers on the same edge as the sync fields.
	assign vga_o.red   = red_r;
	assign vga_o.green = green_r;
	assign vga_o.blue  = blue_r;
	assign vga_o.blank = sync_i.blank;
	assign vga_o.hsync = sync_i.hsync;
	assign vga_o.vsync = sync_i.vsync;

endmodule

`default_nettype wire

// File: hw/fbdev.sv
//////////////////////////////////////////////////
// Framebuffer device top
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module fbdev import fbdev_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [1:0]  s_op_i,
	input  logic [31:0] s_data_i,
	output logic [31:0] s_data_o,
	output bus_req_t    m_req_o,
	input  logic        m_rdy_i,
	input  logic [31:0] m_data_i,
	output vga_out_t    vga_o,
	output logic        vga_rst_o
);

	logic [29:0]        src_addr;
	scan_pos_t          pos;
	vga_out_t           sync;
	logic [FIFO_CW-1:0] fifo_count;
	logic               fifo_write;
	logic               fifo_clear;
	logic               fifo_read;
	logic               fifo_empty;
	px_word_t           fifo_head;

	fb_regs u_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.s_op_i     (s_op_i),
		.s_data_i   (s_data_i),
		.s_data_o   (s_data_o),
		.src_addr_o (src_addr),
		.vga_rst_o  (vga_rst_o)
	);

	scan_timer u_scan (
		.clk_i     (clk_i),
		.vga_rst_o (vga_rst_o),
		.pos_o     (pos),
		.sync_o    (sync)
	);

	fetch_fsm u_fetch (
		.clk_i        (clk_i),
		.vga_rst_o    (vga_rst_o),
		.pos_i        (pos),
		.src_addr_i   (src_addr),
		.m_req_o      (m_req_o),
		.m_rdy_i      (m_rdy_i),
		.fifo_count_i (fifo_count),
		.fifo_write_o (fifo_write),
		.fifo_clear_o (fifo_clear)
	);

	px_fifo u_fifo (
		.clk_i     (clk_i),
		.vga_rst_o (vga_rst_o),
		.clear_i   (fifo_clear),
		.write_i   (fifo_write),
		.data_i    (m_data_i),
		.read_i    (fifo_read),
		.head_o    (fifo_head),
		.empty_o   (fifo_empty),
		.count_o   (fifo_count)
	);

	px_unpack u_unpack (
		.clk_i     (clk_i),
		.vga_rst_o (vga_rst_o),
		.pos_i     (pos),
		.sync_i    (sync),
		.head_i    (fifo_head),
		.empty_i   (fifo_empty),
		.read_o    (fifo_read),
		.vga_o     (vga_o)
	);

endmodule

`default_nettype wire

// File: tb/fbdev_assertions.sv
//////////////////////////////////////////////////
// FIFO and fetch protocol assertions
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module fbdev_assertions import fbdev_pkg::*; (
	input wire logic               clk_i,
	input wire logic               rst_i,
	input wire logic [FIFO_CW-1:0] count_i,
	input wire logic               write_i,
	input wire logic               read_i,
	input wire logic [IF_W-1:0]    in_flight_i
);

	// Writing into a full FIFO would lose a word.
	write_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
		!(write_i && count_i == FIFO_CW'(FIFO_DEPTH)))
		else $error("FIFO written while full");

	read_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
		!(read_i && count_i == '0))
		else $error("FIFO read while empty");

	in_flight_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		in_flight_i <= IF_W'(FIFO_SLACK))
		else $error("Too many reads in flight");

endmodule

`default_nettype wire

// File: tb/tb_fbdev.sv
//////////////////////////////////////////////////
// Framebuffer device testbench
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module tb_fbdev import fbdev_pkg::*; ();

	localparam logic [29:0] BASE = 30'h0002_3400;
	localparam int TIMEOUT = 4 * 800 * 525 + 1000;

	logic        clk_i;
	logic        rst_i;
	logic [1:0]  s_op_i;
	logic [31:0] s_data_i;
	logic [31:0] s_data_o;
	bus_req_t    m_req_o;
	logic        m_rdy_i;
	logic [31:0] m_data_i;
	vga_out_t    vga_o;
	logic        vga_rst_o;

	logic [29:0] pending [$];
	logic [31:0] rng;
	int          cycles;
	logic [11:0] th;
	logic [11:0] tv;
	logic [11:0] ph;
	logic [11:0] pv;
	logic        pvalid;
	int          frame_no;
	int          ref_off;
	int          ref_cnt;

	fbdev DUT (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.s_op_i    (s_op_i),
		.s_data_i  (s_data_i),
		.s_data_o  (s_data_o),
		.m_req_o   (m_req_o),
		.m_rdy_i   (m_rdy_i),
		.m_data_i  (m_data_i),
		.vga_o     (vga_o),
		.vga_rst_o (vga_rst_o)
	);

	bind fetch_fsm fbdev_assertions fetch_chk (
		.clk_i(clk_i), .rst_i(vga_rst_o), .count_i(fifo_count_i),
		.write_i(fifo_write_o), .read_i(1'b0), .in_flight_i(in_flight)
	);

	bind px_fifo fbdev_assertions fifo_chk (
		.clk_i(clk_i), .rst_i(vga_rst_o), .count_i(count_o),
		.write_i(write_i), .read_i(read_i), .in_flight_i('0)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Repeat byte of each memory word stays within 0 to 3.
	function automatic px_word_t mem_word(input logic [29:0] a);
		px_word_t w;
		w.rpt   = {6'd0, a[1:0] ^ a[9:8]};
		w.red   = a[7:0] ^ a[29:22];
		w.green = a[15:8] ^ 8'h3c;
		w.blue  = a[23:16] + a[7:0];
		return w;
	endfunction

	// Word shown at the given offset into the frame.
	function automatic px_word_t expected_word(input logic [29:0] base, input int off);
		return mem_word(base + 30'(off));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic send_cmd(input logic [31:0] data);
		@(posedge clk_i);
		s_op_i   <= PIRWOP;
		s_data_i <= data;
		@(posedge clk_i);
		s_op_i   <= PINOOP;
		@(negedge clk_i);
	endtask

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles without finishing the tests", cycles);
			$display("Checks failed");
			$fatal(1);
		end
	end

	// Memory model with random ready stalls.
	initial begin
		m_rdy_i  = 1'b0;
		m_data_i = 32'd0;
		rng      = 32'h5c6d;
		forever begin
			@(posedge clk_i);
			if (vga_rst_o) begin
				pending.delete();
			end else begin
				if (pending.size() != 0 && m_rdy_i)
					void'(pending.pop_front());
				if (m_req_o.op == PIRDOP && m_rdy_i)
					pending.push_back(m_req_o.addr);
			end
			rng = xorshift(rng);
			m_rdy_i  <= (rng[1:0] != 2'b00);
			m_data_i <= (pending.size() != 0) ? mem_word(pending[0]) : 32'd0;
		end
	end

	// Position that vga_o shows after each edge.
	always @(posedge clk_i) begin
		if (vga_rst_o) begin
			th     <= 12'd0;
			tv     <= 12'd0;
			pvalid <= 1'b0;
		end else begin
			ph     <= th;
			pv     <= tv;
			pvalid <= 1'b1;
			if (th == H_MAX - 12'd1) begin
				th <= 12'd0;
				tv <= (tv == V_MAX - 12'd1) ? 12'd0 : tv + 12'd1;
			end else begin
				th <= th + 12'd1;
			end
		end
	end

	always @(negedge clk_i) begin
		px_word_t w;
		logic     active;
		if (!pvalid) begin
			check_value("vga_o", 32'(vga_o), 32'd0);
		end else begin
			if (ph == 12'd0 && pv == 12'd0) begin
				frame_no = frame_no + 1;
				ref_off  = 0;
				ref_cnt  = 0;
			end
			active = (ph < H_REZ) && (pv < V_REZ);
			check_value("vga_o.blank", 32'(vga_o.blank), 32'(!active));
			check_value("vga_o.hsync", 32'(vga_o.hsync),
				32'(ph >= H_SYNC_START && ph < H_SYNC_END));
			check_value("vga_o.vsync", 32'(vga_o.vsync),
				32'(pv >= V_SYNC_START && pv < V_SYNC_END));
			// Data exists from the second frame on.
			if (active && frame_no >= 2) begin
				w = expected_word(BASE, ref_off);
				check_value("vga_o.red", 32'(vga_o.red), 32'(w.red));
				check_value("vga_o.green", 32'(vga_o.green), 32'(w.green));
				check_value("vga_o.blue", 32'(vga_o.blue), 32'(w.blue));
				if (ref_cnt == int'(w.rpt)) begin
					ref_off = ref_off + 1;
					ref_cnt = 0;
				end else begin
					ref_cnt = ref_cnt + 1;
				end
			end else begin
				check_value("vga_o.colour",
					{8'd0, vga_o.red, vga_o.green, vga_o.blue}, 32'd0);
			end
		end
	end

	initial begin
		rst_i    = 1'b1;
		s_op_i   = PINOOP;
		s_data_i = 32'd0;
		cycles   = 0;
		frame_no = 0;
		ref_off  = 0;
		ref_cnt  = 0;
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;

		// No frame attached yet.
		repeat (20) begin
			@(negedge clk_i);
			check_value("vga_rst_o", 32'(vga_rst_o), 32'd1);
			check_value("m_req_o.op", 32'(m_req_o.op), 32'(PINOOP));
		end

		send_cmd({30'd0, CMDGETINFO});
		check_value("s_data_o", s_data_o, 32'd640);
		send_cmd({30'd1, CMDGETINFO});
		check_value("s_data_o", s_data_o, 32'd480);
		send_cmd({30'd2, CMDGETINFO});
		check_value("s_data_o", s_data_o, 32'd60);
		send_cmd({30'd3, CMDGETINFO});
		check_value("s_data_o", s_data_o, 32'd1);
		send_cmd({30'd4, CMDGETINFO});
		check_value("s_data_o", s_data_o, 32'd0);

		send_cmd(M_ADDR_OFFSET + {BASE, 2'b00});
		check_value("s_data_o", s_data_o, 32'd4);
		check_value("vga_rst_o", 32'(vga_rst_o), 32'd0);

		while (m_req_o.op != PIRDOP)
			@(negedge clk_i);
		check_value("m_req_o.addr", 32'(m_req_o.addr), 32'(BASE));

		// Two data frames are compared by the checker.
		while (frame_no < 4)
			@(negedge clk_i);

		send_cmd(32'hffff_fffc);
		check_value("vga_rst_o", 32'(vga_rst_o), 32'd1);
		@(negedge clk_i);
		check_value("m_req_o.op", 32'(m_req_o.op), 32'(PINOOP));
		repeat (10) @(negedge clk_i);
		check_value("m_req_o.op", 32'(m_req_o.op), 32'(PINOOP));

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: fbdev.f
hw/fbdev_pkg.sv
hw/fb_regs.sv
hw/scan_timer.sv
hw/fetch_fsm.sv
hw/px_fifo.sv
hw/px_unpack.sv
hw/fbdev.sv
tb/fbdev_assertions.sv
tb/tb_fbdev.sv

// File: run_sim.sh
#!/bin/bash
# Build the testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fbdev \
	-f fbdev.f -o sim_fbdev > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_fbdev > sim.log 2>&1

grep -q "All checks passed" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }
